// ==== verilog/vector_unit_pkg.sv ====
// --------------------
// Vector unit package
// Shared types of the SIMD add unit. These are the vector word with
// its byte and half-word views, the lane width select and the request
// record that travels from issue through the queue to execute
// --------------------

package vector_unit_pkg;

    // --------------------
    // Vector data
    // --------------------

    // One 32-bit word, seen either as four bytes or as two half-words
    // Element 0 sits in the least significant bits in both views
    typedef union packed {
        logic [3:0][7:0]  vect4;
        logic [1:0][15:0] vect2;
    } vector_t;

    // Lane width select for the adder
    typedef enum logic {
        BIT8  = 1'b0,
        BIT16 = 1'b1
    } vec_len_t;

    // --------------------
    // Request record
    // --------------------

    // Everything execute needs to produce one result
    // The queue stores it as a single word so the fields stay in step
    typedef struct packed {
        vector_t    operand_a;
        vector_t    operand_b;
        vec_len_t   vector_length;
        // One extend bit per byte, in 16-bit mode only bits 1 and 3 count
        logic [3:0] extend_a;
        logic [3:0] extend_b;
    } vec_req_t;

endpackage : vector_unit_pkg

// ==== verilog/vector_adder.sv ====
// --------------------
// SIMD vector adder
// Adds two 32-bit vectors as four byte lanes or two half-word lanes.
// Each operand element is widened by one bit taken from its extend
// input, and the top bit of each widened sum is the lane's carry
// --------------------

`timescale 1ns/100ps

module vector_adder (
    input  vector_unit_pkg::vector_t  operand_a_i,
    input  vector_unit_pkg::vector_t  operand_b_i,
    input  vector_unit_pkg::vec_len_t vector_length_i,
    input  logic [3:0]                extend_a_i,
    input  logic [3:0]                extend_b_i,
    output vector_unit_pkg::vector_t  result_o,
    output logic [3:0]                carry_o
);

    // --------------------
    // Lane adders
    // --------------------

    always_comb begin : adder_logic
        // Defaults keep every bit driven and the even carries zero in 16-bit mode
        result_o = '0;
        carry_o  = '0;

        if (vector_length_i == vector_unit_pkg::BIT8) begin
            // Four independent byte lanes, each with its own extend and carry bit
            for (int i = 0; i < 4; i++) begin
                {carry_o[i], result_o.vect4[i]} =
                    {extend_a_i[i], operand_a_i.vect4[i]} +
                    {extend_b_i[i], operand_b_i.vect4[i]};
            end
        end else begin
            // Two half-word lanes use only the odd extend and carry bits
            for (int i = 0; i < 2; i++) begin
                {carry_o[2 * i + 1], result_o.vect2[i]} =
                    {extend_a_i[2 * i + 1], operand_a_i.vect2[i]} +
                    {extend_b_i[2 * i + 1], operand_b_i.vect2[i]};
            end
        end
    end : adder_logic

endmodule : vector_adder

// ==== verilog/vector_issue.sv ====
// --------------------
// Vector issue stage
// Accepts requests on the valid/ready input port, packs the loose
// fields into one request word and pushes it into the queue. A credit
// counter mirrors the free queue slots and gates op_ready_o
// --------------------

`timescale 1ns/100ps

module vector_issue #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      op_valid_i,
    output logic                      op_ready_o,
    input  vector_unit_pkg::vector_t  operand_a_i,
    input  vector_unit_pkg::vector_t  operand_b_i,
    input  vector_unit_pkg::vec_len_t vector_length_i,
    input  logic [3:0]                extend_a_i,
    input  logic [3:0]                extend_b_i,
    input  logic                      credit_i,
    output logic                      push_o,
    output vector_unit_pkg::vec_req_t req_o
);

    // Wide enough to hold the full count of FIFO_DEPTH
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    // --------------------
    // Handshake and packing
    // --------------------

    // Ready only while a queue slot is known to be free
    assign op_ready_o = (credit_cnt != '0);
    assign accept     = op_valid_i & op_ready_o;

    // The queue write happens in the same cycle as the acceptance
    assign push_o = accept;

    assign req_o.operand_a     = operand_a_i;
    assign req_o.operand_b     = operand_b_i;
    assign req_o.vector_length = vector_length_i;
    assign req_o.extend_a      = extend_a_i;
    assign req_o.extend_b      = extend_b_i;

    // --------------------
    // Credit counter
    // --------------------

    // An acceptance spends a credit and a credit pulse returns one
    // When both happen together the count stays where it is
    always_ff @(posedge clk_i) begin : credit_counter
        if (rst_i) begin
            credit_cnt <= CNT_W'(FIFO_DEPTH);
        end else begin
            case ({accept, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end : credit_counter

    // The queue must never hand back more credits than it has slots
    a_credit_bound : assert property (
        @(posedge clk_i) disable iff (rst_i)
        credit_cnt <= CNT_W'(FIFO_DEPTH)
    ) else $error("issue credit count above queue depth");

endmodule : vector_issue

// ==== verilog/vector_op_fifo.sv ====
// --------------------
// Vector request queue
// In-order circular buffer of request words between issue and execute.
// Each pop frees one slot and returns a one-cycle credit pulse to the
// issue stage on the following cycle
// --------------------

`timescale 1ns/100ps

module vector_op_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      push_i,
    input  vector_unit_pkg::vec_req_t req_i,
    input  logic                      pop_i,
    output logic                      not_empty_o,
    output vector_unit_pkg::vec_req_t head_o,
    output logic                      credit_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Storage array of request words
    vector_unit_pkg::vec_req_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             credit_q;

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk_i) begin : fifo_write
        if (push_i) begin
            mem[wr_ptr] <= req_i;
        end
    end : fifo_write

    // Head of the queue is always visible to execute
    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    // --------------------
    // Pointers and occupancy
    // --------------------

    // Pointers wrap at FIFO_DEPTH so any depth works, not only powers of two
    always_ff @(posedge clk_i) begin : fifo_control
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) wr_ptr <= '0;
                else                                  wr_ptr <= wr_ptr + 1'b1;
            end

            if (pop_i) begin
                if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) rd_ptr <= '0;
                else                                  rd_ptr <= rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leave the occupancy unchanged
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end : fifo_control

    // Credit goes back one cycle after the pop that freed the slot
    always_ff @(posedge clk_i) begin : credit_return
        if (rst_i) credit_q <= 1'b0;
        else       credit_q <= pop_i;
    end : credit_return

    assign credit_o = credit_q;

    // Issue only pushes while it holds a credit, so a full queue sees no push
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (rst_i)
        push_i |-> (count != CNT_W'(FIFO_DEPTH))
    ) else $error("push into a full request queue");

    a_no_underflow : assert property (
        @(posedge clk_i) disable iff (rst_i)
        pop_i |-> (count != '0)
    ) else $error("pop from an empty request queue");

endmodule : vector_op_fifo

// ==== verilog/vector_execute.sv ====
// --------------------
// Vector execute stage
// Pops the queue head, adds the operands through the SIMD adder and
// holds the sum and carries in an output register until the outside
// accepts them on the valid/ready result port
// --------------------

`timescale 1ns/100ps

module vector_execute (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      not_empty_i,
    input  vector_unit_pkg::vec_req_t head_i,
    output logic                      pop_o,
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    output vector_unit_pkg::vector_t  result_o,
    output logic [3:0]                carry_o
);

    vector_unit_pkg::vector_t sum;
    logic [3:0]               sum_carry;

    logic                     result_valid_q;
    vector_unit_pkg::vector_t result_q;
    logic [3:0]               carry_q;

    // --------------------
    // Adder
    // --------------------

    // The sum is ready in the same cycle as the head
    vector_adder u_adder (
        .operand_a_i     (head_i.operand_a),
        .operand_b_i     (head_i.operand_b),
        .vector_length_i (head_i.vector_length),
        .extend_a_i      (head_i.extend_a),
        .extend_b_i      (head_i.extend_b),
        .result_o        (sum),
        .carry_o         (sum_carry)
    );

    // --------------------
    // Output register
    // --------------------

    // Pop when a request waits and the register is empty or leaving now
    assign pop_o = not_empty_i & (~result_valid_q | result_ready_i);

    always_ff @(posedge clk_i) begin : valid_reg
        if (rst_i) begin
            result_valid_q <= 1'b0;
        end else if (pop_o) begin
            result_valid_q <= 1'b1;
        end else if (result_ready_i) begin
            result_valid_q <= 1'b0;
        end
    end : valid_reg

    // Payload only loads on a pop and holds in every other cycle
    always_ff @(posedge clk_i) begin : payload_reg
        if (pop_o) begin
            result_q <= sum;
            carry_q  <= sum_carry;
        end
    end : payload_reg

    assign result_valid_o = result_valid_q;
    assign result_o       = result_q;
    assign carry_o        = carry_q;

    // A stalled result must not change or vanish before it is taken
    a_result_stable : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (result_valid_o && !result_ready_i) |=>
            (result_valid_o && $stable(result_o) && $stable(carry_o))
    ) else $error("result changed while stalled");

endmodule : vector_execute

// ==== verilog/vector_unit_top.sv ====
// --------------------
// Vector unit top level
// Issue stage, credit-controlled request queue and execute stage
// in a row, with a valid/ready port on each side
// --------------------

`timescale 1ns/100ps

module vector_unit_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      op_valid_i,
    output logic                      op_ready_o,
    input  vector_unit_pkg::vector_t  operand_a_i,
    input  vector_unit_pkg::vector_t  operand_b_i,
    input  vector_unit_pkg::vec_len_t vector_length_i,
    input  logic [3:0]                extend_a_i,
    input  logic [3:0]                extend_b_i,
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    output vector_unit_pkg::vector_t  result_o,
    output logic [3:0]                carry_o
);

    // Issue to queue
    logic                      push;
    vector_unit_pkg::vec_req_t req;
    logic                      credit;

    // Queue to execute
    logic                      pop;
    logic                      not_empty;
    vector_unit_pkg::vec_req_t head;

    vector_issue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_issue (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .op_valid_i      (op_valid_i),
        .op_ready_o      (op_ready_o),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .vector_length_i (vector_length_i),
        .extend_a_i      (extend_a_i),
        .extend_b_i      (extend_b_i),
        .credit_i        (credit),
        .push_o          (push),
        .req_o           (req)
    );

    vector_op_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (push),
        .req_i       (req),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .head_o      (head),
        .credit_o    (credit)
    );

    vector_execute u_execute (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .not_empty_i    (not_empty),
        .head_i         (head),
        .pop_o          (pop),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o),
        .carry_o        (carry_o)
    );

endmodule : vector_unit_top

// ==== verification/tb_clock_gen.sv ====
// --------------------
// Testbench clock and reset
// Free-running clock and an active-high reset held for a set number
// of cycles after the start of the run
// --------------------

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin : clock_source
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end : clock_source

    // Reset drops just after an edge, like the rest of the stimulus
    initial begin : reset_source
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end : reset_source

endmodule : tb_clock_gen

// ==== verification/vector_unit_tb.sv ====
// --------------------
// Vector unit testbench
// Directed tests of the SIMD add unit through its valid/ready ports.
// A reference model predicts each result when its request is accepted
// and a monitor checks the results in order as they leave the unit
// --------------------

`timescale 1ns/100ps

module vector_unit_tb;

    localparam int FIFO_DEPTH  = 4;
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_RANDOM  = 200;
    // Requests offered over all tests, directed and random together
    localparam int TEST_COUNT  = 7 + 6 + 8 + 3 * FIFO_DEPTH + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * 50;
    localparam int DRAIN_LIMIT = 50 * (FIFO_DEPTH + 2);
    localparam logic [31:0] SEED = 32'd99352;

    logic                      clk;
    logic                      rst;
    logic                      op_valid_i;
    logic                      op_ready_o;
    vector_unit_pkg::vector_t  operand_a_i;
    vector_unit_pkg::vector_t  operand_b_i;
    vector_unit_pkg::vec_len_t vector_length_i;
    logic [3:0]                extend_a_i;
    logic [3:0]                extend_b_i;
    logic                      result_valid_o;
    logic                      result_ready_i;
    vector_unit_pkg::vector_t  result_o;
    logic [3:0]                carry_o;

    // Expected results in acceptance order
    vector_unit_pkg::vector_t exp_result_q[$];
    logic [3:0]               exp_carry_q[$];
    int                       accepted = 0;
    string                    cur_test = "reset";
    logic [31:0]              op_rng;
    logic [31:0]              ready_rng;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (10)
    ) u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    vector_unit_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk_i           (clk),
        .rst_i           (rst),
        .op_valid_i      (op_valid_i),
        .op_ready_o      (op_ready_o),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .vector_length_i (vector_length_i),
        .extend_a_i      (extend_a_i),
        .extend_b_i      (extend_b_i),
        .result_valid_o  (result_valid_o),
        .result_ready_i  (result_ready_i),
        .result_o        (result_o),
        .carry_o         (carry_o)
    );

    // --------------------
    // Model and helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each half-word sign goes to both extend bits of its lane
    function automatic logic [3:0] sign_bits(input vector_unit_pkg::vector_t v,
                                             input vector_unit_pkg::vec_len_t len);
        if (len == vector_unit_pkg::BIT8)
            return {v.vect4[3][7], v.vect4[2][7], v.vect4[1][7], v.vect4[0][7]};
        else
            return {v.vect2[1][15], v.vect2[1][15], v.vect2[0][15], v.vect2[0][15]};
    endfunction

    // Each element gains one top bit from its extend bit
    // The lane sum wraps at twice the lane range and its top bit is the carry
    function automatic void model_add(input vector_unit_pkg::vector_t a,
                                      input vector_unit_pkg::vector_t b,
                                      input vector_unit_pkg::vec_len_t len,
                                      input logic [3:0] ea,
                                      input logic [3:0] eb,
                                      output vector_unit_pkg::vector_t res,
                                      output logic [3:0] carry);
        int wa;
        int wb;
        int s;
        res   = '0;
        carry = '0;
        if (len == vector_unit_pkg::BIT8) begin
            for (int i = 0; i < 4; i++) begin
                wa = int'(a.vect4[i]) + (ea[i] ? 256 : 0);
                wb = int'(b.vect4[i]) + (eb[i] ? 256 : 0);
                s  = (wa + wb) % 512;
                res.vect4[i] = 8'(s % 256);
                carry[i]     = (s >= 256);
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                wa = int'(a.vect2[i]) + (ea[2 * i + 1] ? 65536 : 0);
                wb = int'(b.vect2[i]) + (eb[2 * i + 1] ? 65536 : 0);
                s  = (wa + wb) % 131072;
                res.vect2[i]     = 16'(s % 65536);
                carry[2 * i + 1] = (s >= 65536);
            end
        end
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_vector(input string name, input vector_unit_pkg::vector_t exp,
                                input vector_unit_pkg::vector_t act);
        if (exp !== act)
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_carry(input string name, input logic [3:0] exp,
                               input logic [3:0] act);
        if (exp !== act)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
            abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    endtask

    // Sampled on the falling edge, where inputs and outputs are settled
    always @(negedge clk) begin : monitor
        vector_unit_pkg::vector_t r;
        logic [3:0]               c;
        if (rst == 1'b0) begin
            if (result_valid_o && result_ready_i) begin
                if (exp_result_q.size() == 0) begin
                    abort_run("A result left the unit with no request pending");
                end else begin
                    check_vector({cur_test, " result"}, exp_result_q.pop_front(), result_o);
                    check_carry({cur_test, " carry"}, exp_carry_q.pop_front(), carry_o);
                end
            end
            if (op_valid_i && op_ready_o) begin
                model_add(operand_a_i, operand_b_i, vector_length_i, extend_a_i,
                          extend_b_i, r, c);
                exp_result_q.push_back(r);
                exp_carry_q.push_back(c);
                accepted++;
            end
        end
    end : monitor

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before the tests finished");
    end : watchdog

    // --------------------
    // Stimulus
    // --------------------

    task automatic set_request(input logic [31:0] a, input logic [31:0] b,
                               input vector_unit_pkg::vec_len_t len,
                               input logic [3:0] ea, input logic [3:0] eb);
        operand_a_i     = vector_unit_pkg::vector_t'(a);
        operand_b_i     = vector_unit_pkg::vector_t'(b);
        vector_length_i = len;
        extend_a_i      = ea;
        extend_b_i      = eb;
    endtask

    task automatic fill_random_request();
        op_rng = lcg_next(op_rng);
        operand_a_i = vector_unit_pkg::vector_t'(op_rng);
        op_rng = lcg_next(op_rng);
        operand_b_i = vector_unit_pkg::vector_t'(op_rng);
        op_rng = lcg_next(op_rng);
        vector_length_i = vector_unit_pkg::vec_len_t'(op_rng[31]);
        extend_a_i      = op_rng[27:24];
        extend_b_i      = op_rng[19:16];
    endtask

    // Holds valid until the request is taken and returns just after that edge
    task automatic send_request();
        op_valid_i = 1'b1;
        @(negedge clk);
        while (!op_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        op_valid_i = 1'b0;
    endtask

    // Takes every result until nothing is left in flight
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        result_ready_i = 1'b1;
        @(negedge clk);
        while ((exp_result_q.size() != 0 || result_valid_o) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) begin
            abort_run("Results were still pending after the drain limit");
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic test_8bit_lanes();
        cur_test = "8-bit lanes";
        result_ready_i = 1'b1;
        set_request(32'hFF80_7F01, 32'h0180_0101, vector_unit_pkg::BIT8, 4'h0, 4'h0);
        send_request();
        set_request(32'hFFFF_FFFF, 32'h0000_0001, vector_unit_pkg::BIT8, 4'h0, 4'h0);
        send_request();
        set_request(32'h1234_5678, 32'h8765_4321, vector_unit_pkg::BIT8, 4'h0, 4'h0);
        send_request();
        repeat (4) begin
            fill_random_request();
            vector_length_i = vector_unit_pkg::BIT8;
            extend_a_i      = 4'h0;
            extend_b_i      = 4'h0;
            send_request();
        end
        wait_drain();
    endtask

    task automatic test_16bit_lanes();
        cur_test = "16-bit lanes";
        result_ready_i = 1'b1;
        set_request(32'hFFFF_8000, 32'h0001_8000, vector_unit_pkg::BIT16, 4'h0, 4'h0);
        send_request();
        set_request(32'h7FFF_00FF, 32'h0001_FF01, vector_unit_pkg::BIT16, 4'h0, 4'h0);
        send_request();
        repeat (4) begin
            fill_random_request();
            vector_length_i = vector_unit_pkg::BIT16;
            extend_a_i      = 4'h0;
            extend_b_i      = 4'h0;
            send_request();
        end
        wait_drain();
    endtask

    // Extend bits follow the operand signs, so carries are signed sum tops
    task automatic test_sign_extend();
        cur_test = "sign extension";
        result_ready_i = 1'b1;
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 4; k++) begin
                fill_random_request();
                if (k == 0) begin
                    operand_a_i = vector_unit_pkg::vector_t'(32'h8000_8080);
                    operand_b_i = vector_unit_pkg::vector_t'(32'h8000_8080);
                end else if (k == 1) begin
                    operand_a_i = vector_unit_pkg::vector_t'(32'h7FFF_7F7F);
                    operand_b_i = vector_unit_pkg::vector_t'(32'hFFFF_01FF);
                end
                vector_length_i = (m == 0) ? vector_unit_pkg::BIT8 : vector_unit_pkg::BIT16;
                extend_a_i = sign_bits(operand_a_i, vector_length_i);
                extend_b_i = sign_bits(operand_b_i, vector_length_i);
                send_request();
            end
        end
        wait_drain();
    endtask

    // Queue plus output register hold FIFO_DEPTH+1 requests before ready falls
    task automatic test_backpressure();
        int start;
        bit need_new;
        cur_test = "back-pressure";
        start    = accepted;
        need_new = 1'b1;
        result_ready_i = 1'b0;
        for (int cyc = 0; cyc < 3 * FIFO_DEPTH; cyc++) begin
            if (need_new) fill_random_request();
            op_valid_i = 1'b1;
            @(negedge clk);
            need_new = op_ready_o;
            @(posedge clk);
            #1;
        end
        op_valid_i = 1'b0;
        check_count("back-pressure acceptances", FIFO_DEPTH + 1, accepted - start);
        check_count("back-pressure ready", 0, int'(op_ready_o));
        wait_drain();
    endtask

    task automatic test_random_stream();
        int  sent;
        bit  have_req;
        cur_test   = "random stream";
        sent       = 0;
        have_req   = 1'b0;
        while (sent < NUM_RANDOM) begin
            ready_rng = lcg_next(ready_rng);
            result_ready_i = ready_rng[31];
            if (!have_req) begin
                op_rng = lcg_next(op_rng);
                // Roughly three cycles in four offer a new request
                if (op_rng[31:30] != 2'b00) begin
                    fill_random_request();
                    have_req = 1'b1;
                end
            end
            op_valid_i = have_req;
            @(negedge clk);
            if (have_req && op_ready_o) begin
                have_req = 1'b0;
                sent++;
            end
            @(posedge clk);
            #1;
        end
        op_valid_i = 1'b0;
        wait_drain();
    endtask

    initial begin : main
        op_valid_i      = 1'b0;
        operand_a_i     = '0;
        operand_b_i     = '0;
        vector_length_i = vector_unit_pkg::BIT8;
        extend_a_i      = 4'h0;
        extend_b_i      = 4'h0;
        result_ready_i  = 1'b0;
        // Two streams from one seed keep ready and data independent
        op_rng    = SEED;
        ready_rng = lcg_next(~SEED);

        @(negedge rst);
        @(posedge clk);
        #1;
        check_count("reset op_ready", 1, int'(op_ready_o));
        check_count("reset result_valid", 0, int'(result_valid_o));

        test_8bit_lanes();
        test_16bit_lanes();
        test_sign_extend();
        test_backpressure();
        test_random_stream();

        $display("Verification passed");
        $finish;
    end : main

endmodule : vector_unit_tb

// ==== sim.f ====
verilog/vector_unit_pkg.sv
verilog/vector_adder.sv
verilog/vector_issue.sv
verilog/vector_op_fifo.sv
verilog/vector_execute.sv
verilog/vector_unit_top.sv
verification/tb_clock_gen.sv
verification/vector_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the vector unit testbench
# The simulation exit status carries pass or fail

VERILATOR ?= verilator
TOP       ?= vector_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
